/* src/dplru_cfg.svh */
//------------------------------
// Sizing constants for the micro-TLB
// pseudo-LRU selector. Included by the
// packages and by every RTL module.
//------------------------------
`ifndef DPLRU_CFG_SVH
`define DPLRU_CFG_SVH

// Number of micro-TLB entries
`define DPLRU_ENTRY_NUM 16

// Bits needed to number one entry
`define DPLRU_IDX_W 4

// Path bits in the full binary tree
// over all entries, one less than the entry count
`define DPLRU_NODE_NUM 15

`endif

/* src/dplru_entry_pkg.sv */
//------------------------------
// Types for micro-TLB entries: per-entry
// bit vectors and entry numbers.
//------------------------------
`include "dplru_cfg.svh"

package dplru_entry_pkg;

  // One bit per entry
  // Valid bits, one-hot hits, one-hot refill choice
  typedef logic [`DPLRU_ENTRY_NUM-1:0] entry_vec_t;

  // Entry number
  typedef logic [`DPLRU_IDX_W-1:0] entry_idx_t;

endpackage

/* src/dplru_tree_pkg.sv */
//------------------------------
// Types for the pseudo-LRU path-bit tree.
// Heap order, node 0 is the root.
//------------------------------
`include "dplru_cfg.svh"

package dplru_tree_pkg;

  // Path bits, children of node n are 2n+1 and 2n+2
  // A bit of 1 sends the victim walk to the high half
  typedef logic [`DPLRU_NODE_NUM-1:0] tree_vec_t;

endpackage

/* src/dplru_hit_filter.sv */
//------------------------------
// One read-hit port. Decodes the one-hot
// hit to an entry number and raises an
// update strobe unless the hit repeats
// the port's previous entry.
//------------------------------
`timescale 1ns/1ns
`include "dplru_cfg.svh"

module dplru_hit_filter (
  input  logic                        lru_clk,
  input  logic                        cpurst_b,
  input  dplru_entry_pkg::entry_vec_t read_hit,
  input  logic                        read_hit_vld,
  output dplru_entry_pkg::entry_idx_t hit_idx,
  output logic                        hit_updt
);

  dplru_entry_pkg::entry_idx_t last_idx;

  // One-hot to index, anything else decodes to 0
  always_comb
  begin
    hit_idx = '0;
    for (int i = 0; i < `DPLRU_ENTRY_NUM; i++)
    begin
      if (read_hit == (dplru_entry_pkg::entry_vec_t'(1) << i))
        hit_idx = dplru_entry_pkg::entry_idx_t'(i);
    end
  end

  // Last entry this port hit
  always_ff @(posedge lru_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      last_idx <= '0;
    else if (read_hit_vld)
      last_idx <= hit_idx;
  end

  // Repeated hit leaves the tree alone
  assign hit_updt = read_hit_vld && (hit_idx != last_idx);

endmodule

/* src/dplru_tree.sv */
//------------------------------
// Pseudo-LRU path bits. Refill and read
// hits move the nodes on their path to
// point away from the entry, and a walk
// from the root gives the victim.
//------------------------------
`timescale 1ns/1ns
`include "dplru_cfg.svh"

module dplru_tree (
  input  logic                        lru_clk,
  input  logic                        cpurst_b,
  input  dplru_entry_pkg::entry_idx_t hit_idx0,
  input  logic                        hit_updt0,
  input  dplru_entry_pkg::entry_idx_t hit_idx1,
  input  logic                        hit_updt1,
  input  dplru_entry_pkg::entry_idx_t refill_idx,
  input  logic                        refill_vld,
  output dplru_entry_pkg::entry_idx_t victim_idx
);

  localparam int LVL_NUM = `DPLRU_IDX_W;

  dplru_tree_pkg::tree_vec_t tree_q;
  dplru_tree_pkg::tree_vec_t tree_nxt;

  //------------------------------
  // Per-node update
  //------------------------------
  for (genvar lvl = 0; lvl < LVL_NUM; lvl++)
  begin : g_lvl
    for (genvar pos = 0; pos < (1 << lvl); pos++)
    begin : g_node
      // Heap position, and how far to shift an index to get its path prefix
      localparam int NODE  = (1 << lvl) - 1 + pos;
      localparam int SHIFT = LVL_NUM - lvl;

      logic wr_hit;
      logic wr_val;
      logic rd_hit0;
      logic rd_hit1;
      logic rd_val0;
      logic rd_val1;
      logic rd_conflict;

      // Path of the entry passes through this node
      assign wr_hit  = refill_vld && ((refill_idx >> SHIFT) == pos);
      assign rd_hit0 = hit_updt0 && ((hit_idx0 >> SHIFT) == pos);
      assign rd_hit1 = hit_updt1 && ((hit_idx1 >> SHIFT) == pos);

      // Point to the other half
      assign wr_val  = !refill_idx[LVL_NUM-1-lvl];
      assign rd_val0 = !hit_idx0[LVL_NUM-1-lvl];
      assign rd_val1 = !hit_idx1[LVL_NUM-1-lvl];

      // Both ports here but disagree, node keeps its value
      assign rd_conflict = rd_hit0 && rd_hit1 && (rd_val0 != rd_val1);

      // Refill wins over read hits
      assign tree_nxt[NODE] = wr_hit                     ? wr_val  :
                              (rd_hit0 && !rd_conflict)  ? rd_val0 :
                              (rd_hit1 && !rd_conflict)  ? rd_val1 :
                                                           tree_q[NODE];
    end
  end

  always_ff @(posedge lru_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      tree_q <= '0;
    else
      tree_q <= tree_nxt;
  end

  //------------------------------
  // Victim walk
  //------------------------------
  // Each level contributes one index bit, MSB first
  always_comb
  begin
    int node_sel;
    node_sel = 0;
    victim_idx = '0;
    for (int lvl = 0; lvl < LVL_NUM; lvl++)
    begin
      victim_idx[LVL_NUM-1-lvl] = tree_q[node_sel];
      node_sel = 2 * node_sel + 1 + int'(tree_q[node_sel]);
    end
  end

endmodule

/* src/dplru_refill_sel.sv */
//------------------------------
// Refill entry choice. Takes the lowest
// invalid entry, or the tree victim when
// all are valid, registers it on
// refill_on and drives it one-hot.
//------------------------------
`timescale 1ns/1ns
`include "dplru_cfg.svh"

module dplru_refill_sel (
  input  logic                        lru_clk,
  input  logic                        cpurst_b,
  input  dplru_entry_pkg::entry_vec_t entry_vld,
  input  dplru_entry_pkg::entry_idx_t victim_idx,
  input  logic                        refill_on,
  output dplru_entry_pkg::entry_idx_t refill_idx,
  output dplru_entry_pkg::entry_vec_t ref_num
);

  dplru_entry_pkg::entry_idx_t fill_idx;

  // Scan from the top down so the lowest invalid entry wins
  always_comb
  begin
    fill_idx = victim_idx;
    for (int i = `DPLRU_ENTRY_NUM - 1; i >= 0; i--)
    begin
      if (!entry_vld[i])
        fill_idx = dplru_entry_pkg::entry_idx_t'(i);
    end
  end

  // Held until the next refill request
  always_ff @(posedge lru_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      refill_idx <= '0;
    else if (refill_on)
      refill_idx <= fill_idx;
  end

  // One-hot form for the micro-TLB write select
  assign ref_num = dplru_entry_pkg::entry_vec_t'(1) << refill_idx;

endmodule

/* src/dplru_top.sv */
//------------------------------
// Pseudo-LRU replacement selector for
// the 16-entry micro-TLB. Two read-hit
// ports refresh the tree, the refill
// port gets the entry to replace on
// ref_num one cycle after refill_on.
//------------------------------
`timescale 1ns/1ns
`include "dplru_cfg.svh"

module dplru_top (
  input  logic                        lru_clk,
  input  logic                        cpurst_b,
  input  dplru_entry_pkg::entry_vec_t entry_vld,
  input  dplru_entry_pkg::entry_vec_t read_hit0,
  input  dplru_entry_pkg::entry_vec_t read_hit1,
  input  logic                        read_hit_vld0,
  input  logic                        read_hit_vld1,
  input  logic                        refill_on,
  input  logic                        refill_vld,
  output dplru_entry_pkg::entry_vec_t ref_num
);

  dplru_entry_pkg::entry_idx_t hit_idx0;
  dplru_entry_pkg::entry_idx_t hit_idx1;
  dplru_entry_pkg::entry_idx_t refill_idx;
  dplru_entry_pkg::entry_idx_t victim_idx;
  logic                        hit_updt0;
  logic                        hit_updt1;

  //------------------------------
  // Read-hit ports
  //------------------------------
  dplru_hit_filter x_hit_filter0 (
    .lru_clk      (lru_clk),
    .cpurst_b     (cpurst_b),
    .read_hit     (read_hit0),
    .read_hit_vld (read_hit_vld0),
    .hit_idx      (hit_idx0),
    .hit_updt     (hit_updt0)
  );

  dplru_hit_filter x_hit_filter1 (
    .lru_clk      (lru_clk),
    .cpurst_b     (cpurst_b),
    .read_hit     (read_hit1),
    .read_hit_vld (read_hit_vld1),
    .hit_idx      (hit_idx1),
    .hit_updt     (hit_updt1)
  );

  //------------------------------
  // Path bits and refill choice
  //------------------------------
  dplru_tree x_tree (
    .lru_clk    (lru_clk),
    .cpurst_b   (cpurst_b),
    .hit_idx0   (hit_idx0),
    .hit_updt0  (hit_updt0),
    .hit_idx1   (hit_idx1),
    .hit_updt1  (hit_updt1),
    .refill_idx (refill_idx),
    .refill_vld (refill_vld),
    .victim_idx (victim_idx)
  );

  dplru_refill_sel x_refill_sel (
    .lru_clk    (lru_clk),
    .cpurst_b   (cpurst_b),
    .entry_vld  (entry_vld),
    .victim_idx (victim_idx),
    .refill_on  (refill_on),
    .refill_idx (refill_idx),
    .ref_num    (ref_num)
  );

endmodule

/* verification/dplru_assertions.sv */
//------------------------------
// Concurrent checks on the selector's
// ports, bound to the top level.
//------------------------------
`timescale 1ns/1ns

module dplru_assertions (
  input logic                        lru_clk,
  input logic                        cpurst_b,
  input dplru_entry_pkg::entry_vec_t read_hit0,
  input dplru_entry_pkg::entry_vec_t read_hit1,
  input logic                        read_hit_vld0,
  input logic                        read_hit_vld1,
  input logic                        refill_on,
  input dplru_entry_pkg::entry_vec_t ref_num
);

  // Refill select names exactly one entry
  a_ref_onehot: assert property (@(posedge lru_clk) disable iff (!cpurst_b)
    $onehot(ref_num))
    else $error("ref_num is not one-hot");

  // Only a refill request moves the select
  a_ref_hold: assert property (@(posedge lru_clk) disable iff (!cpurst_b)
    !$past(refill_on) |-> $stable(ref_num))
    else $error("ref_num changed without refill_on");

  a_hit0_onehot: assert property (@(posedge lru_clk) disable iff (!cpurst_b)
    read_hit_vld0 |-> $onehot(read_hit0))
    else $error("read_hit0 is not one-hot");

  a_hit1_onehot: assert property (@(posedge lru_clk) disable iff (!cpurst_b)
    read_hit_vld1 |-> $onehot(read_hit1))
    else $error("read_hit1 is not one-hot");

endmodule

bind dplru_top dplru_assertions x_dplru_assertions (
  .lru_clk       (lru_clk),
  .cpurst_b      (cpurst_b),
  .read_hit0     (read_hit0),
  .read_hit1     (read_hit1),
  .read_hit_vld0 (read_hit_vld0),
  .read_hit_vld1 (read_hit_vld1),
  .refill_on     (refill_on),
  .ref_num       (ref_num)
);

/* verification/dplru_tb.sv */
//------------------------------
// Testbench for the micro-TLB pseudo-LRU
// selector. Drives hits and refills, keeps
// a model of the path bits and checks
// ref_num after every refill_on.
//------------------------------
`timescale 1ns/1ns
`include "dplru_cfg.svh"

module dplru_tb;

  localparam int N_RAND  = 200;
  localparam int N_OPS   = 64 + N_RAND;
  localparam int CLK_PER = 8;
  localparam int TIMEOUT = (10 + N_OPS * 4) * CLK_PER * 2;

  logic                        lru_clk;
  logic                        cpurst_b;
  dplru_entry_pkg::entry_vec_t entry_vld;
  dplru_entry_pkg::entry_vec_t read_hit0;
  dplru_entry_pkg::entry_vec_t read_hit1;
  logic                        read_hit_vld0;
  logic                        read_hit_vld1;
  logic                        refill_on;
  logic                        refill_vld;
  dplru_entry_pkg::entry_vec_t ref_num;

  // Model state
  dplru_tree_pkg::tree_vec_t   m_tree;
  dplru_entry_pkg::entry_idx_t m_last0;
  dplru_entry_pkg::entry_idx_t m_last1;
  dplru_entry_pkg::entry_idx_t m_refill;
  dplru_entry_pkg::entry_idx_t drv_idx0;
  dplru_entry_pkg::entry_idx_t drv_idx1;
  dplru_entry_pkg::entry_idx_t exp_q[$];
  logic                        on_seen;
  int                          seed;
  int                          err_cnt;

  dplru_top dplru_top_i (
    .lru_clk       (lru_clk),
    .cpurst_b      (cpurst_b),
    .entry_vld     (entry_vld),
    .read_hit0     (read_hit0),
    .read_hit1     (read_hit1),
    .read_hit_vld0 (read_hit_vld0),
    .read_hit_vld1 (read_hit_vld1),
    .refill_on     (refill_on),
    .refill_vld    (refill_vld),
    .ref_num       (ref_num)
  );

  initial
    lru_clk = 1'b0;
  always #(CLK_PER / 2) lru_clk = ~lru_clk;

  //------------------------------
  // Reference model
  //------------------------------
  // Lowest invalid entry, else follow the path bits from the root
  function automatic dplru_entry_pkg::entry_idx_t exp_refill(
    input dplru_entry_pkg::entry_vec_t vld,
    input dplru_tree_pkg::tree_vec_t   t
  );
    int   node;
    logic found;
    dplru_entry_pkg::entry_idx_t idx;
    node  = 0;
    found = 1'b0;
    idx   = '0;
    for (int e = 0; e < `DPLRU_ENTRY_NUM; e++)
    begin
      if (!found && !vld[e])
      begin
        idx   = dplru_entry_pkg::entry_idx_t'(e);
        found = 1'b1;
      end
    end
    for (int b = `DPLRU_IDX_W - 1; b >= 0 && !found; b--)
    begin
      idx[b] = t[node];
      node   = 2 * node + 1 + int'(t[node]);
    end
    return idx;
  endfunction

  // Path masks and wanted values per source, then the per-node rule
  function automatic dplru_tree_pkg::tree_vec_t next_tree(
    input dplru_tree_pkg::tree_vec_t   t,
    input logic                        u0,
    input dplru_entry_pkg::entry_idx_t h0,
    input logic                        u1,
    input dplru_entry_pkg::entry_idx_t h1,
    input logic                        rv,
    input dplru_entry_pkg::entry_idx_t r
  );
    dplru_tree_pkg::tree_vec_t nt;
    dplru_tree_pkg::tree_vec_t m0;
    dplru_tree_pkg::tree_vec_t m1;
    dplru_tree_pkg::tree_vec_t mr;
    dplru_tree_pkg::tree_vec_t v0;
    dplru_tree_pkg::tree_vec_t v1;
    dplru_tree_pkg::tree_vec_t vr;
    int n;
    nt = t;
    m0 = '0;
    m1 = '0;
    mr = '0;
    v0 = '0;
    v1 = '0;
    vr = '0;
    for (int lvl = 0; lvl < `DPLRU_IDX_W; lvl++)
    begin
      n     = (1 << lvl) - 1 + int'(h0 >> (`DPLRU_IDX_W - lvl));
      m0[n] = u0;
      v0[n] = !h0[`DPLRU_IDX_W-1-lvl];
      n     = (1 << lvl) - 1 + int'(h1 >> (`DPLRU_IDX_W - lvl));
      m1[n] = u1;
      v1[n] = !h1[`DPLRU_IDX_W-1-lvl];
      n     = (1 << lvl) - 1 + int'(r >> (`DPLRU_IDX_W - lvl));
      mr[n] = rv;
      vr[n] = !r[`DPLRU_IDX_W-1-lvl];
    end
    for (int k = 0; k < `DPLRU_NODE_NUM; k++)
    begin
      if (mr[k])
        nt[k] = vr[k];
      else if (m0[k] && m1[k])
      begin
        if (v0[k] == v1[k])
          nt[k] = v0[k];
      end
      else if (m0[k])
        nt[k] = v0[k];
      else if (m1[k])
        nt[k] = v1[k];
    end
    return nt;
  endfunction

  // Called right after a rising edge, with the inputs that edge sampled
  task automatic model_step();
    logic u0;
    logic u1;
    u0 = read_hit_vld0 && (drv_idx0 != m_last0);
    u1 = read_hit_vld1 && (drv_idx1 != m_last1);
    if (refill_on)
      exp_q.push_back(exp_refill(entry_vld, m_tree));
    m_tree = next_tree(m_tree, u0, drv_idx0, u1, drv_idx1, refill_vld, m_refill);
    if (refill_on)
      m_refill = exp_q[$];
    if (read_hit_vld0)
      m_last0 = drv_idx0;
    if (read_hit_vld1)
      m_last1 = drv_idx1;
  endtask

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      err_cnt++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
      $display("test failed");
      $fatal(1, "mismatch");
    end
  endtask

  //------------------------------
  // Stimulus
  //------------------------------
  task automatic drive_cycle(
    input dplru_entry_pkg::entry_vec_t vld,
    input logic                        hv0,
    input dplru_entry_pkg::entry_idx_t h0,
    input logic                        hv1,
    input dplru_entry_pkg::entry_idx_t h1,
    input logic                        ron,
    input logic                        rvld
  );
    entry_vld     = vld;
    read_hit_vld0 = hv0;
    read_hit_vld1 = hv1;
    drv_idx0      = h0;
    drv_idx1      = h1;
    read_hit0     = hv0 ? (dplru_entry_pkg::entry_vec_t'(1) << h0) : '0;
    read_hit1     = hv1 ? (dplru_entry_pkg::entry_vec_t'(1) << h1) : '0;
    refill_on     = ron;
    refill_vld    = rvld;
    @(posedge lru_clk);
    model_step();
    #1;
  endtask

  task automatic refill_pair(input dplru_entry_pkg::entry_vec_t vld);
    drive_cycle(vld, 1'b0, '0, 1'b0, '0, 1'b1, 1'b0);
    drive_cycle(vld, 1'b0, '0, 1'b0, '0, 1'b0, 1'b1);
  endtask

  // ref_num settles one edge after refill_on
  always @(posedge lru_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      on_seen <= 1'b0;
    else
      on_seen <= refill_on;
  end

  always @(negedge lru_clk)
  begin : compare
    dplru_entry_pkg::entry_idx_t exp_idx;
    if (on_seen)
    begin
      check_val(32'(exp_q.size() != 0), 32'd1, "expected refill queued");
      exp_idx = exp_q.pop_front();
      check_val(32'(ref_num), 32'd1 << exp_idx, "ref_num after refill_on");
    end
  end

  initial
  begin : watchdog
    #(TIMEOUT);
    $display("Timeout: the tests did not finish in the allowed time");
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    logic [31:0] rnd;
    dplru_entry_pkg::entry_vec_t vld;
    seed     = 32'hf23c;
    err_cnt  = 0;
    m_tree   = '0;
    m_last0  = '0;
    m_last1  = '0;
    m_refill = '0;
    cpurst_b = 1'b0;
    drv_idx0 = '0;
    drv_idx1 = '0;
    entry_vld     = '1;
    read_hit0     = '0;
    read_hit1     = '0;
    read_hit_vld0 = 1'b0;
    read_hit_vld1 = 1'b0;
    refill_on     = 1'b0;
    refill_vld    = 1'b0;
    repeat (10) @(posedge lru_clk);
    #1;
    cpurst_b = 1'b1;

    // Fresh tree points at entry 0
    refill_pair(16'hffff);
    check_val(32'(ref_num), 32'h0001, "first victim after reset");
    // Lowest invalid entry wins
    refill_pair(16'hffef);
    check_val(32'(ref_num), 32'h0010, "lowest invalid entry");
    refill_pair(16'h7fff);
    check_val(32'(ref_num), 32'h8000, "lowest invalid entry");
    refill_pair(16'h0000);
    // Victim sequence with a full TLB
    repeat (16)
      refill_pair(16'hffff);

    // Repeated hit on port 0 is filtered
    drive_cycle(16'hffff, 1'b1, 4'd5, 1'b0, '0, 1'b0, 1'b0);
    refill_pair(16'hffff);
    drive_cycle(16'hffff, 1'b1, 4'd5, 1'b0, '0, 1'b0, 1'b0);
    refill_pair(16'hffff);

    // Dual hits split at the root
    // Old root value first matches port 0, then port 1
    drive_cycle(16'hffff, 1'b1, 4'd2, 1'b1, 4'd9, 1'b0, 1'b0);
    refill_pair(16'hffff);
    drive_cycle(16'hffff, 1'b1, 4'd4, 1'b1, 4'd14, 1'b0, 1'b0);
    refill_pair(16'hffff);

    // Random mix
    for (int i = 0; i < N_RAND; i++)
    begin
      rnd = $random(seed);
      vld = rnd[20] ? 16'hffff : 16'($random(seed));
      case (rnd[1:0])
        2'd0:
          refill_pair(vld);
        2'd1:
          drive_cycle(vld, rnd[2], rnd[7:4], rnd[3], rnd[11:8], 1'b0, 1'b1);
        default:
          drive_cycle(vld, rnd[2], rnd[7:4], rnd[3], rnd[11:8], 1'b0, 1'b0);
      endcase
    end

    drive_cycle(16'hffff, 1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
    drive_cycle(16'hffff, 1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
    check_val(32'(exp_q.size()), 32'd0, "refills left unchecked");
    if (err_cnt == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+src
src/dplru_entry_pkg.sv
src/dplru_tree_pkg.sv
src/dplru_hit_filter.sv
src/dplru_tree.sv
src/dplru_refill_sel.sv
src/dplru_top.sv
verification/dplru_assertions.sv
verification/dplru_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module dplru_tb \
  -f vlog.f -o dplru_sim &&
sim_out=$(./obj_dir/dplru_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "test passed" && exit 0 || exit 1
